/* common/core_defines.svh */
// Width and size macros shared by the RV32I core
// Register file depth and index width

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and address width
`define XLEN 32

// Register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// Instruction word width
`define INSTR_W 32

`endif

/* common/core_pkg.sv */
// Core package with word, register index and instruction types
// ALU operation, controller state and opcode enums

`default_nettype none

`include "core_defines.svh"

package core_pkg;

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`INSTR_W-1:0]    instr_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_FETCH,
    CTRL_EXECUTE,
    CTRL_MEMORY
  } ctrl_state_e;

  // Major opcodes of the supported instructions
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

endpackage

`default_nettype wire

/* common/core_ifs.sv */
// Fetch interface between controller and fetch unit
// Load/store interface between controller and load/store unit

`default_nettype none

interface fetch_if;
  import core_pkg::*;

  // Controller side
  logic   start;
  logic   pc_set;
  word_t  pc_target;

  // Fetch unit side
  logic   done;
  instr_t instr;
  word_t  pc;

  modport controller (output start, pc_set, pc_target, input done, instr, pc);
  modport unit (input start, pc_set, pc_target, output done, instr, pc);
endinterface

interface lsu_if;
  import core_pkg::*;

  // Access request, latched by the unit at start
  logic  start;
  logic  we;
  word_t addr;
  word_t wdata;

  // Completion and load data
  logic  done;
  word_t rdata;

  modport controller (output start, we, addr, wdata, input done, rdata);
  modport unit (input start, we, addr, wdata, output done, rdata);
endinterface

`default_nettype wire

/* rtl/alu.sv */
// Combinational ALU
// Add, subtract, logic ops, signed set-less-than and pass-b

`default_nettype none

module alu (
  input  core_pkg::alu_op_e op_i,
  input  core_pkg::word_t   a_i,
  input  core_pkg::word_t   b_i,
  output core_pkg::word_t   result_o
);
  import core_pkg::*;

  logic less_than;

  // Signed compare for SLT
  assign less_than = $signed(a_i) < $signed(b_i);

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_OR:     result_o = a_i | b_i;
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SLT:    result_o = word_t'(less_than);
      // LUI immediate passes straight through
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
// Integer register file
// Two asynchronous read ports, one synchronous write port, x0 tied to zero

`default_nettype none

`include "core_defines.svh"

module register_file (
  input  logic                clk,
  input  logic                rst_ni,
  input  core_pkg::reg_addr_t raddr_a_i,
  input  core_pkg::reg_addr_t raddr_b_i,
  output core_pkg::word_t     rdata_a_o,
  output core_pkg::word_t     rdata_b_o,
  input  core_pkg::reg_addr_t waddr_i,
  input  logic                we_i,
  input  core_pkg::word_t     wdata_i
);
  import core_pkg::*;

  word_t regs [`NUM_REGS];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 always reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

/* fetch/fetch_unit.sv */
// Instruction fetch unit
// Program counter, next-PC selection and instruction bus handshake

`default_nettype none

module fetch_unit (
  input  logic             clk,
  input  logic             rst_ni,
  input  core_pkg::word_t  boot_addr_i,
  fetch_if.unit            fetch,
  output logic             instr_req_o,
  output core_pkg::word_t  instr_addr_o,
  input  logic             instr_gnt_i,
  input  logic             instr_rvalid_i,
  input  core_pkg::instr_t instr_rdata_i
);
  import core_pkg::*;

  logic   booted_q;
  logic   req_q, wait_q, done_q;
  word_t  pc_q;
  word_t  next_pc;
  instr_t instr_q;

  // Branch or jump target, else sequential
  assign next_pc = fetch.pc_set ? fetch.pc_target : pc_q + 32'd4;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      booted_q <= 1'b0;
      req_q    <= 1'b0;
      wait_q   <= 1'b0;
      done_q   <= 1'b0;
      pc_q     <= '0;
    end else begin
      done_q <= wait_q & instr_rvalid_i;
      // Track the boot address until the first fetch
      if (!booted_q) begin
        pc_q <= boot_addr_i;
      end
      if (fetch.start) begin
        booted_q <= 1'b1;
        req_q    <= 1'b1;
        if (booted_q) begin
          pc_q <= next_pc;
        end
      end
      // Request phase, then response phase
      if (req_q && instr_gnt_i) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end
      if (wait_q && instr_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wait_q && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_q;

  assign fetch.done  = done_q;
  assign fetch.instr = instr_q;
  assign fetch.pc    = pc_q;

endmodule

`default_nettype wire

/* lsu/load_store_unit.sv */
// Load/store unit for word accesses
// Data bus handshake and load result register

`default_nettype none

module load_store_unit (
  input  logic            clk,
  input  logic            rst_ni,
  lsu_if.unit             lsu,
  output logic            data_req_o,
  output logic            data_we_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  core_pkg::word_t data_rdata_i
);
  import core_pkg::*;

  logic  req_q, wait_q, done_q;
  logic  we_q;
  word_t addr_q, wdata_q, rdata_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
      done_q <= 1'b0;
      we_q   <= 1'b0;
    end else begin
      // Stores also complete on the rvalid acknowledgement
      done_q <= wait_q & data_rvalid_i;
      if (lsu.start) begin
        req_q <= 1'b1;
        we_q  <= lsu.we;
      end
      if (req_q && data_gnt_i) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end
      if (wait_q && data_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lsu.start) begin
      addr_q  <= lsu.addr;
      wdata_q <= lsu.wdata;
    end
    if (wait_q && data_rvalid_i && !we_q) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o   = req_q;
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  assign lsu.done  = done_q;
  assign lsu.rdata = rdata_q;

endmodule

`default_nettype wire

/* rtl/core_controller.sv */
// Instruction decode and operand selection
// Idle/fetch/execute/memory sequencing FSM
// Branch decision, jump targets and writeback select

`default_nettype none

module core_controller (
  input  logic                clk,
  input  logic                rst_ni,
  input  logic                fetch_enable_i,
  fetch_if.controller         fetch,
  lsu_if.controller           lsu,
  output core_pkg::reg_addr_t rs1_addr_o,
  output core_pkg::reg_addr_t rs2_addr_o,
  input  core_pkg::word_t     rs1_data_i,
  input  core_pkg::word_t     rs2_data_i,
  output core_pkg::reg_addr_t rd_addr_o,
  output logic                rd_we_o,
  output core_pkg::word_t     rd_wdata_o,
  output core_pkg::alu_op_e   alu_op_o,
  output core_pkg::word_t     alu_a_o,
  output core_pkg::word_t     alu_b_o,
  input  core_pkg::word_t     alu_result_i
);
  import core_pkg::*;

  ctrl_state_e state_q, state_d;

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  word_t       imm_i, imm_s, imm_b, imm_u, imm_j;
  logic        is_alu_wb, is_load, is_store, is_branch, is_jal;
  logic        is_mem, branch_taken;
  word_t       link_addr;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign opcode = opcode_e'(fetch.instr[6:0]);
  assign funct3 = fetch.instr[14:12];
  assign funct7 = fetch.instr[31:25];

  assign rs1_addr_o = fetch.instr[19:15];
  assign rs2_addr_o = fetch.instr[24:20];
  assign rd_addr_o  = fetch.instr[11:7];

  // Sign-extended immediates for each format
  assign imm_i = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
  assign imm_s = {{20{fetch.instr[31]}}, fetch.instr[31:25], fetch.instr[11:7]};
  assign imm_b = {{19{fetch.instr[31]}}, fetch.instr[31], fetch.instr[7],
                  fetch.instr[30:25], fetch.instr[11:8], 1'b0};
  assign imm_u = {fetch.instr[31:12], 12'b0};
  assign imm_j = {{11{fetch.instr[31]}}, fetch.instr[31], fetch.instr[19:12],
                  fetch.instr[20], fetch.instr[30:21], 1'b0};

  always_comb begin
    alu_op_o  = ALU_ADD;
    alu_b_o   = rs2_data_i;
    is_alu_wb = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    // Unsupported encodings fall through with no side effects
    case (opcode)
      OPC_OP: begin
        is_alu_wb = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
        case (funct3)
          3'b000:  alu_op_o = funct7[5] ? ALU_SUB : ALU_ADD;
          3'b010:  alu_op_o = ALU_SLT;
          3'b100:  alu_op_o = ALU_XOR;
          3'b110:  alu_op_o = ALU_OR;
          3'b111:  alu_op_o = ALU_AND;
          default: is_alu_wb = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        is_alu_wb = (funct3 == 3'b000);
        alu_b_o   = imm_i;
      end
      OPC_LUI: begin
        is_alu_wb = 1'b1;
        alu_op_o  = ALU_PASS_B;
        alu_b_o   = imm_u;
      end
      OPC_LOAD: begin
        is_load = (funct3 == 3'b010);
        alu_b_o = imm_i;
      end
      OPC_STORE: begin
        is_store = (funct3 == 3'b010);
        alu_b_o  = imm_s;
      end
      OPC_BRANCH: begin
        // Equality comes from a zero difference
        is_branch = (funct3[2:1] == 2'b00);
        alu_op_o  = ALU_SUB;
      end
      OPC_JAL: is_jal = 1'b1;
      default: ;
    endcase
  end

  assign alu_a_o = rs1_data_i;

  // BNE has funct3[0] set and inverts the zero test
  assign branch_taken = is_branch && ((alu_result_i == '0) != funct3[0]);
  assign is_mem       = is_load | is_store;
  assign link_addr    = fetch.pc + 32'd4;

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    fetch.start = 1'b0;
    lsu.start   = 1'b0;
    case (state_q)
      CTRL_IDLE: begin
        if (fetch_enable_i) begin
          fetch.start = 1'b1;
          state_d     = CTRL_FETCH;
        end
      end
      CTRL_FETCH: begin
        if (fetch.done) begin
          state_d = CTRL_EXECUTE;
        end
      end
      CTRL_EXECUTE: begin
        if (is_mem) begin
          lsu.start = 1'b1;
          state_d   = CTRL_MEMORY;
        end else begin
          fetch.start = 1'b1;
          state_d     = CTRL_FETCH;
        end
      end
      CTRL_MEMORY: begin
        if (lsu.done) begin
          fetch.start = 1'b1;
          state_d     = CTRL_FETCH;
        end
      end
      default: state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next-PC override for taken branches and JAL
  assign fetch.pc_set    = (state_q == CTRL_EXECUTE) && (branch_taken || is_jal);
  assign fetch.pc_target = fetch.pc + (is_jal ? imm_j : imm_b);

  // Access request, latched by the unit on start
  assign lsu.we    = is_store;
  assign lsu.addr  = alu_result_i;
  assign lsu.wdata = rs2_data_i;

  // Writeback
  assign rd_we_o = ((state_q == CTRL_EXECUTE) && (is_alu_wb || is_jal)) ||
                   ((state_q == CTRL_MEMORY) && lsu.done && is_load);

  always_comb begin
    if (is_jal) begin
      rd_wdata_o = link_addr;
    end else if (is_load) begin
      rd_wdata_o = lsu.rdata;
    end else begin
      rd_wdata_o = alu_result_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/core_top.sv */
// Top level of the multicycle RV32I core
// Connects controller, fetch unit, load/store unit, register file and ALU

`default_nettype none

module core_top (
  input  logic               clk,
  input  logic               rst_ni,

  // Instruction bus
  output logic               instr_req_o,
  output core_pkg::word_t    instr_addr_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  core_pkg::instr_t   instr_rdata_i,

  // Data bus
  output logic               data_req_o,
  output logic               data_we_o,
  output core_pkg::word_t    data_addr_o,
  output core_pkg::word_t    data_wdata_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  core_pkg::word_t    data_rdata_i,

  // Start-up control
  input  core_pkg::word_t    boot_addr_i,
  input  logic               fetch_enable_i
);
  import core_pkg::*;

  fetch_if fetch_bus ();
  lsu_if   lsu_bus ();

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t rd_addr;
  logic      rd_we;
  word_t     rd_wdata;
  alu_op_e   alu_op;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;

  core_controller u_controller (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .fetch          (fetch_bus.controller),
    .lsu            (lsu_bus.controller),
    .rs1_addr_o     (rs1_addr),
    .rs2_addr_o     (rs2_addr),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .rd_addr_o      (rd_addr),
    .rd_we_o        (rd_we),
    .rd_wdata_o     (rd_wdata),
    .alu_op_o       (alu_op),
    .alu_a_o        (alu_a),
    .alu_b_o        (alu_b),
    .alu_result_i   (alu_result)
  );

  fetch_unit u_fetch (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .boot_addr_i    (boot_addr_i),
    .fetch          (fetch_bus.unit),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i)
  );

  load_store_unit u_lsu (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .lsu            (lsu_bus.unit),
    .data_req_o     (data_req_o),
    .data_we_o      (data_we_o),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i)
  );

  register_file u_regfile (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .waddr_i   (rd_addr),
    .we_i      (rd_we),
    .wdata_i   (rd_wdata)
  );

  alu u_alu (
    .op_i     (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

endmodule

`default_nettype wire

/* tests/core_props.sv */
// Bus protocol assertions for the core top level
// Attached to core_top with bind

`default_nettype none

module core_props (
  input logic            clk,
  input logic            rst_ni,
  input logic            instr_req_o,
  input logic            instr_gnt_i,
  input core_pkg::word_t instr_addr_o,
  input logic            data_req_o,
  input logic            data_we_o,
  input logic            data_gnt_i,
  input core_pkg::word_t data_addr_o,
  input core_pkg::word_t data_wdata_o
);
  timeunit 1ns;
  timeprecision 1ns;

  int violations = 0;

  req_low_after_reset: assert property (@(posedge clk)
    $rose(rst_ni) |-> (!instr_req_o && !data_req_o))
    else begin
      violations++;
      $error("Bus request high right after reset");
    end

  // Request held steady until granted
  instr_req_stable: assert property (@(posedge clk) disable iff (!rst_ni)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else begin
      violations++;
      $error("Instruction request changed before grant");
    end

  data_req_stable: assert property (@(posedge clk) disable iff (!rst_ni)
    (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_addr_o) &&
                                     $stable(data_we_o) && $stable(data_wdata_o)))
    else begin
      violations++;
      $error("Data request changed before grant");
    end

  one_bus_at_a_time: assert property (@(posedge clk) disable iff (!rst_ni)
    !(instr_req_o && data_req_o))
    else begin
      violations++;
      $error("Instruction and data requests high together");
    end

endmodule

bind core_top core_props u_props (
  .clk          (clk),
  .rst_ni       (rst_ni),
  .instr_req_o  (instr_req_o),
  .instr_gnt_i  (instr_gnt_i),
  .instr_addr_o (instr_addr_o),
  .data_req_o   (data_req_o),
  .data_we_o    (data_we_o),
  .data_gnt_i   (data_gnt_i),
  .data_addr_o  (data_addr_o),
  .data_wdata_o (data_wdata_o)
);

`default_nettype wire

/* tests/core_tb.sv */
// Testbench for the RV32I core
// Clock, reset, bus memory models, directed tests, timeout and summary

`default_nettype none

module core_tb;
  timeunit 1ns;
  timeprecision 1ns;
  import core_pkg::*;

  localparam word_t BOOT = 32'h0000_0100;
  // About five tests of up to 60 instructions at up to 12 cycles each
  localparam int LIMIT = 4000;

  logic clk, rst_ni, fetch_enable_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i;
  word_t instr_addr_o, boot_addr_i;
  instr_t instr_rdata_i;
  logic data_req_o, data_we_o, data_gnt_i, data_rvalid_i;
  word_t data_addr_o, data_wdata_o, data_rdata_i;

  word_t imem [256];
  word_t dmem [256];
  word_t fetch_log [$];
  word_t store_addr_q [$];
  word_t store_data_q [$];
  word_t exp_addr [$];
  word_t exp_data [$];
  int errors = 0;
  int cycles = 0;
  int prog_idx;
  integer seed = 75;
  logic stall_mode = 1'b0;
  logic req_seen;

  core_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (instr_req_o) req_seen = 1'b1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, the core stopped making progress", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic int gap();
    return stall_mode ? int'($unsigned($random(seed)) % 4) : 0;
  endfunction

  ////////////////////////////////////////
  // Bus memory models
  ////////////////////////////////////////

  initial begin
    word_t a;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    forever begin
      @(negedge clk);
      instr_gnt_i = 1'b0;
      instr_rvalid_i = 1'b0;
      if (rst_ni && instr_req_o) begin
        repeat (gap()) @(negedge clk);
        instr_gnt_i = 1'b1;
        a = instr_addr_o;
        fetch_log.push_back(a);
        @(negedge clk);
        instr_gnt_i = 1'b0;
        repeat (gap()) @(negedge clk);
        instr_rvalid_i = 1'b1;
        instr_rdata_i = imem[a[9:2]];
      end
    end
  end

  initial begin
    word_t a;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
    forever begin
      @(negedge clk);
      data_gnt_i = 1'b0;
      data_rvalid_i = 1'b0;
      if (rst_ni && data_req_o) begin
        repeat (gap()) @(negedge clk);
        data_gnt_i = 1'b1;
        a = data_addr_o;
        if (data_we_o) begin
          dmem[a[9:2]] = data_wdata_o;
          store_addr_q.push_back(a);
          store_data_q.push_back(data_wdata_o);
        end
        @(negedge clk);
        data_gnt_i = 1'b0;
        repeat (gap()) @(negedge clk);
        data_rvalid_i = 1'b1;
        data_rdata_i = dmem[a[9:2]];
      end
    end
  end

  ////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////

  function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd,
                                   logic [6:0] opc);
    return {imm, rs1, (opc == 7'b0000011) ? 3'b010 : 3'b000, rd, opc};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(word_t instr);
    imem[prog_idx] = instr;
    prog_idx++;
  endtask

  // Halt loop everywhere, address-dependent data words
  task automatic clear_memories();
    for (int i = 0; i < 256; i++) begin
      imem[i] = j_type(21'd0, 5'd0);
      dmem[i] = 32'hC0DE_0000 ^ (i << 2) ^ (i << 18);
    end
    prog_idx = int'(BOOT[9:2]);
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic apply_reset();
    @(negedge clk);
    fetch_enable_i = 1'b0;
    rst_ni = 1'b0;
    repeat (8) @(negedge clk);
    fetch_log.delete();
    store_addr_q.delete();
    store_data_q.delete();
    req_seen = 1'b0;
    rst_ni = 1'b1;
  endtask

  // Run until the core fetches the halt loop that follows the program
  task automatic start_and_wait();
    word_t halt_addr;
    halt_addr = word_t'(prog_idx) << 2;
    @(negedge clk);
    fetch_enable_i = 1'b1;
    while (fetch_log.size() == 0 || fetch_log[$] != halt_addr) @(posedge clk);
  endtask

  task automatic compare_stores(string name);
    assert (store_addr_q.size() == exp_addr.size()) else begin
      errors++;
      $display("Mismatch at %0t: %s store count expected %0d got %0d", $time, name,
               exp_addr.size(), store_addr_q.size());
    end
    for (int i = 0; i < exp_addr.size() && i < store_addr_q.size(); i++) begin
      assert (store_addr_q[i] == exp_addr[i]) else begin
        errors++;
        $display("Mismatch at %0t: %s data_addr_o expected %h got %h", $time, name,
                 exp_addr[i], store_addr_q[i]);
      end
      assert (store_data_q[i] == exp_data[i]) else begin
        errors++;
        $display("Mismatch at %0t: %s data_wdata_o expected %h got %h", $time, name,
                 exp_data[i], store_data_q[i]);
      end
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic verify_startup();
    clear_memories();
    apply_reset();
    repeat (20) @(negedge clk);
    assert (!req_seen) else begin
      errors++;
      $display("Instruction request seen while fetch_enable_i was low");
    end
    fetch_enable_i = 1'b1;
    while (fetch_log.size() == 0) @(posedge clk);
    assert (fetch_log[0] == BOOT) else begin
      errors++;
      $display("Mismatch at %0t: instr_addr_o expected %h got %h", $time, BOOT, fetch_log[0]);
    end
  endtask

  task automatic load_alu_program();
    word_t a, b, u;
    a = 32'd100;
    b = -32'sd7;
    u = 32'h1234_5000;
    clear_memories();
    emit(i_type(12'd100, 5'd0, 5'd1, 7'b0010011));
    emit(i_type(12'hFF9, 5'd0, 5'd2, 7'b0010011));
    emit({20'h12345, 5'd3, 7'b0110111});
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
    emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd6));
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd7));
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd8));
    emit(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd9));
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd11));
    emit(i_type(12'h678, 5'd3, 5'd12, 7'b0010011));
    exp_data = '{u, a + b, a - b, a & b, a | b, a ^ b, 32'd1, 32'd0, u + 32'h678};
    // Results sit in x3 to x9, then x11 and x12
    for (int i = 0; i < 9; i++) begin
      emit(s_type(12'h200 + 12'(i * 4), (i < 7) ? 5'(i + 3) : 5'(i + 4)));
      exp_addr.push_back(32'h200 + i * 4);
    end
  endtask

  task automatic alu_ops();
    load_alu_program();
    apply_reset();
    start_and_wait();
    compare_stores("alu");
  endtask

  task automatic load_store_words();
    clear_memories();
    dmem[32'h300 >> 2] = 32'h0000_1000;
    dmem[32'h304 >> 2] = 32'hFFFF_FFF0;
    exp_addr = '{32'h300, 32'h304, 32'h308};
    exp_data = '{dmem[32'h300 >> 2] + 32'd5, dmem[32'h304 >> 2] - 32'd16, 32'd0};
    emit(i_type(12'h300, 5'd0, 5'd1, 7'b0000011));
    emit(i_type(12'h304, 5'd0, 5'd2, 7'b0000011));
    emit(i_type(12'd5, 5'd1, 5'd1, 7'b0010011));
    emit(i_type(12'hFF0, 5'd2, 5'd2, 7'b0010011));
    emit(s_type(12'h300, 5'd1));
    emit(s_type(12'h304, 5'd2));
    emit(i_type(12'd55, 5'd0, 5'd0, 7'b0010011));
    emit(s_type(12'h308, 5'd0));
    apply_reset();
    start_and_wait();
    compare_stores("load/store");
  endtask

  task automatic branch_and_jump();
    word_t exp_fetch [$];
    clear_memories();
    emit(i_type(12'd5, 5'd0, 5'd1, 7'b0010011));
    emit(i_type(12'd5, 5'd0, 5'd2, 7'b0010011));
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b000));
    emit(i_type(12'd1, 5'd0, 5'd3, 7'b0010011));
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));
    emit(b_type(13'd8, 5'd0, 5'd1, 3'b000));
    emit(b_type(13'd8, 5'd0, 5'd1, 3'b001));
    emit(i_type(12'd2, 5'd0, 5'd3, 7'b0010011));
    emit(j_type(21'd8, 5'd5));
    emit(i_type(12'd3, 5'd0, 5'd3, 7'b0010011));
    emit(s_type(12'h400, 5'd5));
    emit(s_type(12'h404, 5'd3));
    exp_fetch = '{0, 4, 8, 16, 20, 24, 32, 40, 44, 48};
    exp_addr = '{32'h400, 32'h404};
    exp_data = '{BOOT + 32'd32 + 32'd4, 32'd0};
    apply_reset();
    start_and_wait();
    compare_stores("control");
    for (int i = 0; i < exp_fetch.size(); i++) begin
      assert (i < fetch_log.size() && fetch_log[i] == BOOT + exp_fetch[i]) else begin
        errors++;
        $display("Mismatch at %0t: instr_addr_o fetch %0d expected %h got %h", $time, i,
                 BOOT + exp_fetch[i], (i < fetch_log.size()) ? fetch_log[i] : 32'hx);
      end
    end
  endtask

  task automatic stalled_alu_ops();
    stall_mode = 1'b1;
    load_alu_program();
    apply_reset();
    start_and_wait();
    compare_stores("back-pressure");
    stall_mode = 1'b0;
  endtask

  initial begin
    rst_ni = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i = BOOT;
    verify_startup();
    alu_ops();
    load_store_words();
    branch_and_jump();
    stalled_alu_ops();
    repeat (4) @(negedge clk);
    errors += UUT.u_props.violations;
    $display("Summary: %0d errors, %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/core_pkg.sv
common/core_ifs.sv
rtl/alu.sv
rtl/register_file.sv
fetch/fetch_unit.sv
lsu/load_store_unit.sv
rtl/core_controller.sv
rtl/core_top.sv
tests/core_props.sv
tests/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
